/* compile.f */
+incdir+test
hdl/rsp_prep_mem_pkg.sv
hdl/rsp_prep_ctrl_pkg.sv
hdl/rsp_prep_op_fsm.sv
hdl/rsp_prep_rd_addr_gen.sv
hdl/rsp_prep_dc_remove.sv
hdl/rsp_prep_wr_back.sv
hdl/rsp_prep_top.sv
test/rsp_prep_checker.sv
test/rsp_prep_asserts.sv
test/tb_rsp_prep.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rsp_prep -f compile.f

# Assertion failures are counted by the testbench, so let the run continue past them
./obj_dir/Vtb_rsp_prep +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST RESULT: PASS" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

/* test/rsp_prep_tb_cases.svh */
typedef struct packed {
  rsp_prep_ctrl_pkg::op_id_t   op_id;
  rsp_prep_ctrl_pkg::ttl_t     ttl;
  logic                        ping_pong;
  rsp_prep_mem_pkg::frame_id_t frame_id;
  rsp_prep_mem_pkg::sample_t   dc_i;
  rsp_prep_mem_pkg::sample_t   dc_q;
  logic [3:0]                  mem_ack_dly;
  logic [3:0]                  fin_ack_dly;
} tb_case_t;

localparam int NUM_CASES = 5;

// op id, TTL, ping/pong, frame, DC I, DC Q, mem-ack delay, finish-ack delay
// Rows 1 and 2 push both halves into saturation in both directions
localparam tb_case_t CASES [0:NUM_CASES-1] = '{
  '{4'h3, 4'd2, 1'b0, 2'd1, 16'sd100,    -16'sd50,   4'd0, 4'd2},
  '{4'h5, 4'd0, 1'b1, 2'd2, 16'sh7000,   -16'sh7000, 4'd3, 4'd0},
  '{4'h9, 4'd1, 1'b1, 2'd0, -16'sh8000,  16'sh7FFF,  4'd1, 4'd4},
  '{4'hC, 4'd3, 1'b0, 2'd3, 16'sd0,      16'sd0,     4'd5, 4'd1},
  '{4'h7, 4'd1, 1'b0, 2'd0, -16'sd200,   16'sd300,   4'd2, 4'd0}
};

/* test/tb_rsp_prep.sv */
`timescale 1ns/1ps

module tb_rsp_prep;

  import rsp_prep_mem_pkg::*;
  import rsp_prep_ctrl_pkg::*;

  `include "rsp_prep_tb_cases.svh"

  localparam int          RST_CYCLES     = 16;
  localparam int          CYCLES_PER_RUN = 400;
  localparam int          MEM_DEPTH      = 1 << L1_ADDR_W;
  localparam logic [31:0] LCG_SEED       = 32'd56562;

  logic       clk;
  logic       rst_n;
  logic       i_cmd_req;
  op_id_t     i_cmd_op_id;
  ttl_t       i_cmd_ttl;
  logic       o_cmd_ack;
  logic       i_start_req;
  logic       i_start_ping_pong;
  frame_id_t  i_start_frame_id;
  logic       o_start_ack;
  logic       o_mem_req;
  bank_mask_t o_mem_bm;
  logic       i_mem_ack;
  logic       o_finish_req;
  op_id_t     o_finish_op_id;
  ttl_t       o_finish_ttl_left;
  logic       i_finish_ack;
  sample_t    i_dc_i;
  sample_t    i_dc_q;
  logic       o_rd_en;
  l1_addr_t   o_rd_addr;
  l1_data_t   i_rd_data;
  logic       o_wr_en;
  l1_addr_t   o_wr_addr;
  l1_data_t   o_wr_data;

  l1_data_t mem [0:MEM_DEPTH-1];
  logic     rd_pend      = 1'b0;
  l1_addr_t rd_pend_addr = '0;
  int       chk_cnt;
  int       chk_err;
  int       run_cnt;
  int       asrt_fail;
  int       other_err    = 0;

  always #5 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int total_runs();
    int n;
    n = 0;
    for (int r = 0; r < NUM_CASES; r++) begin
      n += (CASES[r].ttl == '0) ? 1 : int'(CASES[r].ttl);
    end
    return n;
  endfunction

  rsp_prep_top rsp_prep_top_inst (
    .clk (clk), .rst_n (rst_n),
    .i_cmd_req (i_cmd_req), .i_cmd_op_id (i_cmd_op_id), .i_cmd_ttl (i_cmd_ttl),
    .o_cmd_ack (o_cmd_ack),
    .i_start_req (i_start_req), .i_start_ping_pong (i_start_ping_pong),
    .i_start_frame_id (i_start_frame_id), .o_start_ack (o_start_ack),
    .o_mem_req (o_mem_req), .o_mem_bm (o_mem_bm), .i_mem_ack (i_mem_ack),
    .o_finish_req (o_finish_req), .o_finish_op_id (o_finish_op_id),
    .o_finish_ttl_left (o_finish_ttl_left), .i_finish_ack (i_finish_ack),
    .i_dc_i (i_dc_i), .i_dc_q (i_dc_q),
    .o_rd_en (o_rd_en), .o_rd_addr (o_rd_addr), .i_rd_data (i_rd_data),
    .o_wr_en (o_wr_en), .o_wr_addr (o_wr_addr), .o_wr_data (o_wr_data)
  );

  rsp_prep_checker checker_inst (
    .clk (clk), .rst_n (rst_n),
    .i_cmd_req (i_cmd_req), .i_cmd_ack (o_cmd_ack),
    .i_start_req (i_start_req), .i_start_ack (o_start_ack),
    .i_mem_req (o_mem_req), .i_mem_bm (o_mem_bm), .i_mem_ack (i_mem_ack),
    .i_finish_req (o_finish_req), .i_finish_op_id (o_finish_op_id),
    .i_finish_ttl_left (o_finish_ttl_left), .i_finish_ack (i_finish_ack),
    .i_rd_en (o_rd_en), .i_rd_addr (o_rd_addr), .i_rd_data (i_rd_data),
    .i_wr_en (o_wr_en), .i_wr_addr (o_wr_addr), .i_wr_data (o_wr_data),
    .o_chk_cnt (chk_cnt), .o_err_cnt (chk_err), .o_run_cnt (run_cnt)
  );

  ////////////////////////////////
  // L1 memory model
  ////////////////////////////////
  task automatic fill_mem();
    logic [31:0] s;
    s = LCG_SEED;
    for (int a = 0; a < MEM_DEPTH; a++) begin
      s      = lcg_next(s);
      mem[a] = s;
    end
  endtask

  // Read data shows up one cycle after o_rd_en
  always @(negedge clk) begin
    i_rd_data    = rd_pend ? mem[rd_pend_addr] : '0;
    rd_pend      = o_rd_en;
    rd_pend_addr = o_rd_addr;
    if (o_wr_en) begin
      mem[o_wr_addr] = o_wr_data;
    end
  end

  ////////////////////////////////
  // Stimulus
  ////////////////////////////////
  task automatic send_start(input tb_case_t c);
    i_start_req       = 1'b1;
    i_start_ping_pong = c.ping_pong;
    i_start_frame_id  = c.frame_id;
    @(negedge clk);
    i_start_req = 1'b0;
  endtask

  task automatic run_case(input tb_case_t c);
    int runs;
    runs = (c.ttl == '0) ? 1 : int'(c.ttl);
    // Start while idle, no ack expected
    send_start(c);
    @(negedge clk);
    i_dc_i      = c.dc_i;
    i_dc_q      = c.dc_q;
    i_cmd_req   = 1'b1;
    i_cmd_op_id = c.op_id;
    i_cmd_ttl   = c.ttl;
    @(negedge clk);
    i_cmd_req = 1'b0;
    while (!o_cmd_ack) @(negedge clk);
    for (int n = 0; n < runs; n++) begin
      send_start(c);
      while (!o_mem_req) @(negedge clk);
      repeat (c.mem_ack_dly) @(negedge clk);
      i_mem_ack = 1'b1;
      @(negedge clk);
      i_mem_ack = 1'b0;
      // Stray command in the middle of a run
      i_cmd_req   = 1'b1;
      i_cmd_op_id = ~c.op_id;
      @(negedge clk);
      i_cmd_req = 1'b0;
      while (!o_finish_req) @(negedge clk);
      repeat (c.fin_ack_dly) @(negedge clk);
      i_finish_ack = 1'b1;
      @(negedge clk);
      i_finish_ack = 1'b0;
    end
    @(negedge clk);
  endtask

  initial begin
    clk               = 1'b0;
    rst_n             = 1'b0;
    i_cmd_req         = 1'b0;
    i_cmd_op_id       = '0;
    i_cmd_ttl         = '0;
    i_start_req       = 1'b0;
    i_start_ping_pong = 1'b0;
    i_start_frame_id  = '0;
    i_mem_ack         = 1'b0;
    i_finish_ack      = 1'b0;
    i_dc_i            = '0;
    i_dc_q            = '0;
    i_rd_data         = '0;
    fill_mem();
    repeat (RST_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    for (int r = 0; r < NUM_CASES; r++) begin
      run_case(CASES[r]);
    end
    repeat (8) @(negedge clk);
    if (run_cnt != total_runs()) begin
      other_err++;
      $display("Only %0d of %0d runs completed", run_cnt, total_runs());
    end
    asrt_fail = rsp_prep_top_inst.asserts_inst.fail_cnt;
    $display("Summary: checks=%0d errors=%0d assertion_failures=%0d other_errors=%0d",
             chk_cnt, chk_err, asrt_fail, other_err);
    if (chk_err == 0 && asrt_fail == 0 && other_err == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (RST_CYCLES + CYCLES_PER_RUN * total_runs()) @(posedge clk);
    $display("Timeout: the runs did not complete in %0d cycles",
             RST_CYCLES + CYCLES_PER_RUN * total_runs());
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* test/rsp_prep_asserts.sv */
`timescale 1ns/1ps

module rsp_prep_asserts (
  input logic clk,
  input logic rst_n,
  input logic i_cmd_ack,
  input logic i_start_ack,
  input logic i_mem_req,
  input logic i_finish_req,
  input logic i_finish_ack,
  input logic i_rd_en,
  input logic i_wr_en
);

  // Running count of failed assertions
  int fail_cnt = 0;

  ////////////////////////////////
  // Ack strobes
  ////////////////////////////////
  ap_cmd_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    i_cmd_ack |=> !i_cmd_ack)
    else begin
      fail_cnt++;
      $error("o_cmd_ack held for more than one cycle");
    end

  ap_start_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    i_start_ack |=> !i_start_ack)
    else begin
      fail_cnt++;
      $error("o_start_ack held for more than one cycle");
    end

  ////////////////////////////////
  // Finish and memory request
  ////////////////////////////////
  ap_finish_hold: assert property (@(posedge clk) disable iff (!rst_n)
    i_finish_req && !i_finish_ack |=> i_finish_req)
    else begin
      fail_cnt++;
      $error("o_finish_req dropped before i_finish_ack");
    end

  // No L1 traffic before the banks are granted
  ap_no_access_in_req: assert property (@(posedge clk) disable iff (!rst_n)
    !(i_mem_req && (i_rd_en || i_wr_en)))
    else begin
      fail_cnt++;
      $error("L1 access while o_mem_req is high");
    end

endmodule

bind rsp_prep_top rsp_prep_asserts asserts_inst (
  .clk          (clk),
  .rst_n        (rst_n),
  .i_cmd_ack    (o_cmd_ack),
  .i_start_ack  (o_start_ack),
  .i_mem_req    (o_mem_req),
  .i_finish_req (o_finish_req),
  .i_finish_ack (i_finish_ack),
  .i_rd_en      (o_rd_en),
  .i_wr_en      (o_wr_en)
);

/* test/rsp_prep_checker.sv */
`timescale 1ns/1ps

module rsp_prep_checker (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         i_cmd_req,
  input  logic                         i_cmd_ack,
  input  logic                         i_start_req,
  input  logic                         i_start_ack,
  input  logic                         i_mem_req,
  input  rsp_prep_mem_pkg::bank_mask_t i_mem_bm,
  input  logic                         i_mem_ack,
  input  logic                         i_finish_req,
  input  rsp_prep_ctrl_pkg::op_id_t    i_finish_op_id,
  input  rsp_prep_ctrl_pkg::ttl_t      i_finish_ttl_left,
  input  logic                         i_finish_ack,
  input  logic                         i_rd_en,
  input  rsp_prep_mem_pkg::l1_addr_t   i_rd_addr,
  input  rsp_prep_mem_pkg::l1_data_t   i_rd_data,
  input  logic                         i_wr_en,
  input  rsp_prep_mem_pkg::l1_addr_t   i_wr_addr,
  input  rsp_prep_mem_pkg::l1_data_t   i_wr_data,
  output int                           o_chk_cnt,
  output int                           o_err_cnt,
  output int                           o_run_cnt
);

  import rsp_prep_mem_pkg::*;
  import rsp_prep_ctrl_pkg::*;

  `include "rsp_prep_tb_cases.svh"

  // Cycle offsets counted from the posedge that samples i_mem_ack
  localparam int RD_FIRST = 2;
  localparam int RD_LAST  = RD_FIRST + SMP_CNT - 1;
  localparam int WR_FIRST = RD_FIRST + 3;
  localparam int WR_LAST  = WR_FIRST + SMP_CNT - 1;

  op_state_e exp_state;
  tb_case_t  cur;
  int        row;
  int        runs_left;
  int        cyc;
  int        k;
  logic      cmd_ack_exp;
  logic      start_ack_exp;
  logic      rd_exp;
  logic      wr_exp;
  logic      rd_pend;
  l1_addr_t  rd_pend_addr;
  l1_addr_t  src;
  l1_addr_t  dst;
  l1_data_t  rd_log [0:(1 << L1_ADDR_W)-1];

  // Clamp to the signed 16-bit range
  function automatic sample_t sat_diff(input sample_t a, input sample_t b);
    int d;
    d = int'(a) - int'(b);
    if (d > 32767) begin
      d = 32767;
    end else if (d < -32768) begin
      d = -32768;
    end
    return sample_t'(d);
  endfunction

  function automatic l1_data_t exp_word(input l1_data_t w, input sample_t di, input sample_t dq);
    return {sat_diff(w[L1_DATA_W-1:SAMPLE_W], di), sat_diff(w[SAMPLE_W-1:0], dq)};
  endfunction

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    o_chk_cnt++;
    if (got !== exp) begin
      o_err_cnt++;
      $display("[ERROR] %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic quiet_checks();
    check_eq("o_mem_req", i_mem_req, 1'b0);
    check_eq("o_finish_req", i_finish_req, 1'b0);
    check_eq("o_rd_en", i_rd_en, 1'b0);
    check_eq("o_wr_en", i_wr_en, 1'b0);
  endtask

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_state     = ST_IDLE;
      row           = 0;
      runs_left     = 0;
      cyc           = 0;
      cmd_ack_exp   = 1'b0;
      start_ack_exp = 1'b0;
      rd_pend       = 1'b0;
      o_chk_cnt     = 0;
      o_err_cnt     = 0;
      o_run_cnt     = 0;
    end else begin
      // Memory returns the word one cycle after the read
      if (rd_pend) begin
        rd_log[rd_pend_addr] = i_rd_data;
      end
      rd_pend      = i_rd_en;
      rd_pend_addr = i_rd_addr;

      check_eq("o_cmd_ack", i_cmd_ack, cmd_ack_exp);
      check_eq("o_start_ack", i_start_ack, start_ack_exp);
      cmd_ack_exp   = 1'b0;
      start_ack_exp = 1'b0;

      case (exp_state)
        ST_IDLE: begin
          quiet_checks();
          if (i_cmd_req) begin
            if (row >= NUM_CASES) begin
              o_err_cnt++;
              $display("Command accepted beyond the end of the stimulus table");
            end else begin
              cur         = CASES[row];
              runs_left   = (cur.ttl == '0) ? 1 : int'(cur.ttl);
              src         = cur.ping_pong ? PONG_SRC_BASE[cur.frame_id]
                                          : PING_SRC_BASE[cur.frame_id];
              dst         = cur.ping_pong ? PONG_DST_BASE[cur.frame_id]
                                          : PING_DST_BASE[cur.frame_id];
              cmd_ack_exp = 1'b1;
              exp_state   = ST_WAIT_START;
            end
          end
        end
        ST_WAIT_START: begin
          quiet_checks();
          if (i_start_req) begin
            start_ack_exp = 1'b1;
            exp_state     = ST_MEM_REQ;
          end
        end
        ST_MEM_REQ: begin
          check_eq("o_mem_req", i_mem_req, 1'b1);
          check_eq("o_mem_bm", i_mem_bm, cur.ping_pong ? PONG_BANK_MASK[cur.frame_id]
                                                       : PING_BANK_MASK[cur.frame_id]);
          check_eq("o_rd_en", i_rd_en, 1'b0);
          check_eq("o_wr_en", i_wr_en, 1'b0);
          if (i_mem_ack) begin
            cyc       = 0;
            exp_state = ST_RUN;
          end
        end
        ST_RUN: begin
          cyc++;
          rd_exp = (cyc >= RD_FIRST) && (cyc <= RD_LAST);
          wr_exp = (cyc >= WR_FIRST) && (cyc <= WR_LAST);
          check_eq("o_mem_req", i_mem_req, 1'b0);
          check_eq("o_rd_en", i_rd_en, rd_exp);
          if (rd_exp) begin
            check_eq("o_rd_addr", i_rd_addr, src + l1_addr_t'(cyc - RD_FIRST));
          end
          check_eq("o_wr_en", i_wr_en, wr_exp);
          if (wr_exp) begin
            k = cyc - WR_FIRST;
            check_eq("o_wr_addr", i_wr_addr, dst + l1_addr_t'(k));
            check_eq("o_wr_data", i_wr_data,
                     exp_word(rd_log[src + l1_addr_t'(k)], cur.dc_i, cur.dc_q));
          end
          check_eq("o_finish_req", i_finish_req, 1'b0);
          // Finish request is due right after the last write
          if (cyc >= WR_LAST) begin
            exp_state = ST_FINISH;
          end
        end
        ST_FINISH: begin
          check_eq("o_finish_req", i_finish_req, 1'b1);
          check_eq("o_finish_op_id", i_finish_op_id, cur.op_id);
          check_eq("o_finish_ttl_left", i_finish_ttl_left, ttl_t'(runs_left - 1));
          check_eq("o_rd_en", i_rd_en, 1'b0);
          check_eq("o_wr_en", i_wr_en, 1'b0);
          if (i_finish_ack) begin
            runs_left--;
            o_run_cnt++;
            if (runs_left == 0) begin
              row++;
              exp_state = ST_IDLE;
            end else begin
              exp_state = ST_WAIT_START;
            end
          end
        end
        default: begin
          exp_state = ST_IDLE;
        end
      endcase
    end
  end

endmodule

/* hdl/rsp_prep_top.sv */
`timescale 1ns/1ps

module rsp_prep_top (
  input  logic                         clk,
  input  logic                         rst_n,
  // Command
  input  logic                         i_cmd_req,
  input  rsp_prep_ctrl_pkg::op_id_t    i_cmd_op_id,
  input  rsp_prep_ctrl_pkg::ttl_t      i_cmd_ttl,
  output logic                         o_cmd_ack,
  // Start
  input  logic                         i_start_req,
  input  logic                         i_start_ping_pong,
  input  rsp_prep_mem_pkg::frame_id_t  i_start_frame_id,
  output logic                         o_start_ack,
  // Memory request
  output logic                         o_mem_req,
  output rsp_prep_mem_pkg::bank_mask_t o_mem_bm,
  input  logic                         i_mem_ack,
  // Finish
  output logic                         o_finish_req,
  output rsp_prep_ctrl_pkg::op_id_t    o_finish_op_id,
  output rsp_prep_ctrl_pkg::ttl_t      o_finish_ttl_left,
  input  logic                         i_finish_ack,
  // DC offsets
  input  rsp_prep_mem_pkg::sample_t    i_dc_i,
  input  rsp_prep_mem_pkg::sample_t    i_dc_q,
  // L1 read port
  output logic                         o_rd_en,
  output rsp_prep_mem_pkg::l1_addr_t   o_rd_addr,
  input  rsp_prep_mem_pkg::l1_data_t   i_rd_data,
  // L1 write port
  output logic                         o_wr_en,
  output rsp_prep_mem_pkg::l1_addr_t   o_wr_addr,
  output rsp_prep_mem_pkg::l1_data_t   o_wr_data
);

  import rsp_prep_mem_pkg::*;

  logic     core_start;
  logic     core_finish;
  l1_addr_t src_base;
  l1_addr_t dst_base;

  // Stage 1 to stage 2
  logic     rd_vld;
  blk_idx_t rd_idx;
  logic     rd_last;

  // Stage 2 to stage 3
  logic     dc_vld;
  blk_idx_t dc_idx;
  logic     dc_last;
  l1_data_t dc_data;

  ////////////////////////////////
  // Operation control
  ////////////////////////////////
  rsp_prep_op_fsm op_fsm_inst (
    .clk               (clk),
    .rst_n             (rst_n),
    .i_cmd_req         (i_cmd_req),
    .i_cmd_op_id       (i_cmd_op_id),
    .i_cmd_ttl         (i_cmd_ttl),
    .o_cmd_ack         (o_cmd_ack),
    .i_start_req       (i_start_req),
    .i_start_ping_pong (i_start_ping_pong),
    .i_start_frame_id  (i_start_frame_id),
    .o_start_ack       (o_start_ack),
    .o_mem_req         (o_mem_req),
    .o_mem_bm          (o_mem_bm),
    .i_mem_ack         (i_mem_ack),
    .o_finish_req      (o_finish_req),
    .o_finish_op_id    (o_finish_op_id),
    .o_finish_ttl_left (o_finish_ttl_left),
    .i_finish_ack      (i_finish_ack),
    .o_core_start      (core_start),
    .i_core_finish     (core_finish),
    .o_src_base        (src_base),
    .o_dst_base        (dst_base)
  );

  ////////////////////////////////
  // Sample pipeline
  ////////////////////////////////
  rsp_prep_rd_addr_gen rd_addr_gen_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_core_start (core_start),
    .i_src_base   (src_base),
    .o_rd_en      (o_rd_en),
    .o_rd_addr    (o_rd_addr),
    .o_vld        (rd_vld),
    .o_idx        (rd_idx),
    .o_last       (rd_last)
  );

  rsp_prep_dc_remove dc_remove_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_vld  (rd_vld),
    .i_idx  (rd_idx),
    .i_last (rd_last),
    .i_data (i_rd_data),
    .i_dc_i (i_dc_i),
    .i_dc_q (i_dc_q),
    .o_vld  (dc_vld),
    .o_idx  (dc_idx),
    .o_last (dc_last),
    .o_data (dc_data)
  );

  rsp_prep_wr_back wr_back_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_vld         (dc_vld),
    .i_idx         (dc_idx),
    .i_last        (dc_last),
    .i_data        (dc_data),
    .i_dst_base    (dst_base),
    .o_wr_en       (o_wr_en),
    .o_wr_addr     (o_wr_addr),
    .o_wr_data     (o_wr_data),
    .o_core_finish (core_finish)
  );

endmodule

/* hdl/rsp_prep_wr_back.sv */
`timescale 1ns/1ps

module rsp_prep_wr_back (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       i_vld,
  input  rsp_prep_mem_pkg::blk_idx_t i_idx,
  input  logic                       i_last,
  input  rsp_prep_mem_pkg::l1_data_t i_data,
  input  rsp_prep_mem_pkg::l1_addr_t i_dst_base,
  output logic                       o_wr_en,
  output rsp_prep_mem_pkg::l1_addr_t o_wr_addr,
  output rsp_prep_mem_pkg::l1_data_t o_wr_data,
  output logic                       o_core_finish
);

  import rsp_prep_mem_pkg::*;

  // Finish goes out together with the last write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_wr_en       <= 1'b0;
      o_core_finish <= 1'b0;
    end else begin
      o_wr_en       <= i_vld;
      o_core_finish <= i_vld & i_last;
    end
  end

  always_ff @(posedge clk) begin
    if (i_vld) begin
      o_wr_addr <= i_dst_base + l1_addr_t'(i_idx);
      o_wr_data <= i_data;
    end
  end

endmodule

/* hdl/rsp_prep_dc_remove.sv */
`timescale 1ns/1ps

module rsp_prep_dc_remove (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       i_vld,
  input  rsp_prep_mem_pkg::blk_idx_t i_idx,
  input  logic                       i_last,
  input  rsp_prep_mem_pkg::l1_data_t i_data,
  input  rsp_prep_mem_pkg::sample_t  i_dc_i,
  input  rsp_prep_mem_pkg::sample_t  i_dc_q,
  output logic                       o_vld,
  output rsp_prep_mem_pkg::blk_idx_t o_idx,
  output logic                       o_last,
  output rsp_prep_mem_pkg::l1_data_t o_data
);

  import rsp_prep_mem_pkg::*;

  // One extra bit catches the overflow
  function automatic sample_t sat_sub(input sample_t a, input sample_t b);
    logic [SAMPLE_W:0] diff;
    diff = {a[SAMPLE_W-1], a} - {b[SAMPLE_W-1], b};
    if (diff[SAMPLE_W] != diff[SAMPLE_W-1]) begin
      sat_sub = diff[SAMPLE_W] ? SAMPLE_MIN : SAMPLE_MAX;
    end else begin
      sat_sub = diff[SAMPLE_W-1:0];
    end
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_vld  <= 1'b0;
      o_last <= 1'b0;
    end else begin
      o_vld  <= i_vld;
      o_last <= i_vld & i_last;
    end
  end

  ////////////////////////////////
  // I and Q handled separately
  ////////////////////////////////
  always_ff @(posedge clk) begin
    if (i_vld) begin
      o_idx  <= i_idx;
      o_data <= {sat_sub(i_data[L1_DATA_W-1 -: SAMPLE_W], i_dc_i),
                 sat_sub(i_data[SAMPLE_W-1:0], i_dc_q)};
    end
  end

endmodule

/* hdl/rsp_prep_rd_addr_gen.sv */
`timescale 1ns/1ps

module rsp_prep_rd_addr_gen (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       i_core_start,
  input  rsp_prep_mem_pkg::l1_addr_t i_src_base,
  output logic                       o_rd_en,
  output rsp_prep_mem_pkg::l1_addr_t o_rd_addr,
  output logic                       o_vld,
  output rsp_prep_mem_pkg::blk_idx_t o_idx,
  output logic                       o_last
);

  import rsp_prep_mem_pkg::*;

  logic     rd_active;
  blk_idx_t rd_cnt;
  logic     rd_cnt_end;

  assign rd_cnt_end = (rd_cnt == blk_idx_t'(SMP_CNT - 1));
  assign o_rd_en    = rd_active;
  assign o_rd_addr  = i_src_base + l1_addr_t'(rd_cnt);

  // One read per cycle over the whole block
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_active <= 1'b0;
      rd_cnt    <= '0;
    end else if (i_core_start) begin
      rd_active <= 1'b1;
      rd_cnt    <= '0;
    end else if (rd_active) begin
      rd_cnt <= rd_cnt + 1'b1;
      if (rd_cnt_end) begin
        rd_active <= 1'b0;
      end
    end
  end

  // Tags follow the memory latency
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_vld  <= 1'b0;
      o_last <= 1'b0;
    end else begin
      o_vld  <= rd_active;
      o_last <= rd_active & rd_cnt_end;
    end
  end

  always_ff @(posedge clk) begin
    o_idx <= rd_cnt;
  end

endmodule

/* hdl/rsp_prep_op_fsm.sv */
`timescale 1ns/1ps

module rsp_prep_op_fsm (
  input  logic                         clk,
  input  logic                         rst_n,
  // Command
  input  logic                         i_cmd_req,
  input  rsp_prep_ctrl_pkg::op_id_t    i_cmd_op_id,
  input  rsp_prep_ctrl_pkg::ttl_t      i_cmd_ttl,
  output logic                         o_cmd_ack,
  // Start
  input  logic                         i_start_req,
  input  logic                         i_start_ping_pong,
  input  rsp_prep_mem_pkg::frame_id_t  i_start_frame_id,
  output logic                         o_start_ack,
  // Memory request
  output logic                         o_mem_req,
  output rsp_prep_mem_pkg::bank_mask_t o_mem_bm,
  input  logic                         i_mem_ack,
  // Finish
  output logic                         o_finish_req,
  output rsp_prep_ctrl_pkg::op_id_t    o_finish_op_id,
  output rsp_prep_ctrl_pkg::ttl_t      o_finish_ttl_left,
  input  logic                         i_finish_ack,
  // Core
  output logic                         o_core_start,
  input  logic                         i_core_finish,
  output rsp_prep_mem_pkg::l1_addr_t   o_src_base,
  output rsp_prep_mem_pkg::l1_addr_t   o_dst_base
);

  import rsp_prep_mem_pkg::*;
  import rsp_prep_ctrl_pkg::*;

  op_state_e state;
  op_id_t    op_id;
  ttl_t      ttl_cnt;
  logic      ping_pong;
  frame_id_t frame_id;

  ////////////////////////////////
  // Buffer selection
  ////////////////////////////////
  assign o_src_base = ping_pong ? PONG_SRC_BASE[frame_id] : PING_SRC_BASE[frame_id];
  assign o_dst_base = ping_pong ? PONG_DST_BASE[frame_id] : PING_DST_BASE[frame_id];
  assign o_mem_bm   = ping_pong ? PONG_BANK_MASK[frame_id] : PING_BANK_MASK[frame_id];

  // Runs left once the current one is done
  assign o_finish_op_id    = op_id;
  assign o_finish_ttl_left = ttl_cnt - ttl_t'(1);

  ////////////////////////////////
  // Sequencing
  ////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= ST_IDLE;
      op_id        <= '0;
      ttl_cnt      <= '0;
      ping_pong    <= 1'b0;
      frame_id     <= '0;
      o_cmd_ack    <= 1'b0;
      o_start_ack  <= 1'b0;
      o_mem_req    <= 1'b0;
      o_core_start <= 1'b0;
      o_finish_req <= 1'b0;
    end else begin
      // Strobes default low
      o_cmd_ack    <= 1'b0;
      o_start_ack  <= 1'b0;
      o_core_start <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (i_cmd_req) begin
            op_id     <= i_cmd_op_id;
            ttl_cnt   <= (i_cmd_ttl == '0) ? ttl_t'(1) : i_cmd_ttl;
            o_cmd_ack <= 1'b1;
            state     <= ST_WAIT_START;
          end
        end
        ST_WAIT_START: begin
          if (i_start_req) begin
            ping_pong   <= i_start_ping_pong;
            frame_id    <= i_start_frame_id;
            o_start_ack <= 1'b1;
            o_mem_req   <= 1'b1;
            state       <= ST_MEM_REQ;
          end
        end
        ST_MEM_REQ: begin
          // Banks granted, kick the core
          if (i_mem_ack) begin
            o_mem_req    <= 1'b0;
            o_core_start <= 1'b1;
            state        <= ST_RUN;
          end
        end
        ST_RUN: begin
          if (i_core_finish) begin
            o_finish_req <= 1'b1;
            state        <= ST_FINISH;
          end
        end
        ST_FINISH: begin
          if (i_finish_ack) begin
            o_finish_req <= 1'b0;
            ttl_cnt      <= ttl_cnt - ttl_t'(1);
            if (ttl_cnt == ttl_t'(1)) begin
              state <= ST_IDLE;
            end else begin
              state <= ST_WAIT_START;
            end
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

/* hdl/rsp_prep_ctrl_pkg.sv */
package rsp_prep_ctrl_pkg;

  ////////////////////////////////
  // Operation control sizes
  ////////////////////////////////
  localparam int OP_ID_W = 4;
  localparam int TTL_W   = 4;

  typedef logic [OP_ID_W-1:0] op_id_t;
  // Run count, zero is treated as one run
  typedef logic [TTL_W-1:0]   ttl_t;

  ////////////////////////////////
  // Operation FSM states
  ////////////////////////////////
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WAIT_START,
    ST_MEM_REQ,
    ST_RUN,
    ST_FINISH
  } op_state_e;

endpackage

/* hdl/rsp_prep_mem_pkg.sv */
package rsp_prep_mem_pkg;

  ////////////////////////////////
  // L1 memory geometry
  ////////////////////////////////
  localparam int L1_ADDR_W   = 12;
  localparam int L1_DATA_W   = 32;
  localparam int L1_BANK_NUM = 4;
  localparam int SAMPLE_W    = 16;

  // Block and frame sizes
  localparam int SMP_CNT = 16;
  localparam int FRM_NUM = 4;

  typedef logic [L1_ADDR_W-1:0]         l1_addr_t;
  // Upper half I, lower half Q
  typedef logic [L1_DATA_W-1:0]         l1_data_t;
  typedef logic signed [SAMPLE_W-1:0]   sample_t;
  typedef logic [L1_BANK_NUM-1:0]       bank_mask_t;
  typedef logic [$clog2(SMP_CNT)-1:0]   blk_idx_t;
  typedef logic [$clog2(FRM_NUM)-1:0]   frame_id_t;

  // Saturation limits of one component
  localparam sample_t SAMPLE_MAX = 16'sh7FFF;
  localparam sample_t SAMPLE_MIN = 16'sh8000;

  ////////////////////////////////
  // Per-frame buffer tables
  ////////////////////////////////
  localparam l1_addr_t PING_SRC_BASE [0:FRM_NUM-1] = '{12'h000, 12'h040, 12'h080, 12'h0C0};
  localparam l1_addr_t PONG_SRC_BASE [0:FRM_NUM-1] = '{12'h100, 12'h140, 12'h180, 12'h1C0};
  localparam l1_addr_t PING_DST_BASE [0:FRM_NUM-1] = '{12'h400, 12'h440, 12'h480, 12'h4C0};
  localparam l1_addr_t PONG_DST_BASE [0:FRM_NUM-1] = '{12'h500, 12'h540, 12'h580, 12'h5C0};

  // Banks claimed for each buffer
  localparam bank_mask_t PING_BANK_MASK [0:FRM_NUM-1] = '{4'b0001, 4'b0011, 4'b0101, 4'b1001};
  localparam bank_mask_t PONG_BANK_MASK [0:FRM_NUM-1] = '{4'b0010, 4'b1100, 4'b1010, 4'b0110};

endpackage
